/* run.sh */
#!/bin/sh
# Build the register map testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module register_map_tb -f sources.f
if ./obj_dir/Vregister_map_tb | tee /dev/stderr | grep "Simulation PASSED" > /dev/null; then
	echo "Run passed"
else
	echo "Run failed"
	exit 1
fi

/* source/address_decoder.sv */
// ========================================================================
// Address register, one-hot write select and read byte mux
// ========================================================================
`timescale 1ns/1ps

module address_decoder (
	input logic system_clock,
	input logic reset,
	input logic [register_map_pkg::ADDRESS_WIDTH-1:0] address,
	input logic [register_map_pkg::SETTING_BYTES*register_map_pkg::BYTE_WIDTH-1:0]
		setting_bytes,	// Narrow fields already zero-extended
	input logic [register_map_pkg::SNAPSHOT_BYTES*register_map_pkg::BYTE_WIDTH-1:0]
		snapshot_bytes,
	output logic [register_map_pkg::SETTING_BYTES-1:0] write_select,
	output logic [register_map_pkg::BYTE_WIDTH-1:0] read_data
);

	register_map_pkg::reg_address_t address_q;	// Registered command address
	logic [register_map_pkg::BYTE_WIDTH-1:0] setting_byte;
	logic [register_map_pkg::BYTE_WIDTH-1:0] snapshot_byte;

	assign setting_byte = setting_bytes[int'(address_q) * register_map_pkg::BYTE_WIDTH
		+: register_map_pkg::BYTE_WIDTH];
	// Status bytes start at the marker count address
	assign snapshot_byte = snapshot_bytes[
		(int'(address_q) - int'(register_map_pkg::ADDR_MARKER_COUNT))
		* register_map_pkg::BYTE_WIDTH +: register_map_pkg::BYTE_WIDTH];

	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			address_q <= register_map_pkg::ADDR_B_DOR_LIMIT;
			write_select <= '0;
		end else begin
			address_q <= register_map_pkg::reg_address_t'(address);
			case (address_q) inside
				[register_map_pkg::ADDR_B_DOR_LIMIT:register_map_pkg::ADDR_SEQ_LIMIT]:
					write_select <= {{(register_map_pkg::SETTING_BYTES - 1){1'b0}}, 1'b1}
						<< address_q;
				default: write_select <= '0;	// Status bytes are read only
			endcase
		end
	end

	// Read byte, one cycle behind the select
	always_ff @(posedge system_clock) begin
		case (address_q) inside
			[register_map_pkg::ADDR_B_DOR_LIMIT:register_map_pkg::ADDR_SEQ_LIMIT]:
				read_data <= setting_byte;
			[register_map_pkg::ADDR_MARKER_COUNT:register_map_pkg::ADDR_STATUS_7_0]:
				read_data <= snapshot_byte;
			default: read_data <= '0;	// Unassigned address
		endcase
	end

endmodule

/* source/read_sequencer.sv */
// ========================================================================
// Read command handshake FSM, loads and holds the read result
// ========================================================================
`timescale 1ns/1ps

module read_sequencer (
	input logic system_clock,
	input logic reset,
	input logic read_byte,		// Request from the command front end
	input logic [register_map_pkg::BYTE_WIDTH-1:0] read_data,
	output logic [register_map_pkg::BYTE_WIDTH-1:0] read_result,
	output logic done_read_byte
);

	register_map_pkg::read_state_t read_state;
	logic read_request;

	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			read_request <= 1'b0;
			read_result <= '0;
			read_state <= register_map_pkg::READ_IDLE;
		end else begin
			read_request <= read_byte;
			case (read_state)
				register_map_pkg::READ_IDLE: begin
					read_result <= '0;
					if (read_request) read_state <= register_map_pkg::READ_LOAD;
				end
				register_map_pkg::READ_LOAD: begin
					read_result <= read_data;	// Decoder output is settled by now
					read_state <= register_map_pkg::READ_DONE;
				end
				register_map_pkg::READ_DONE: begin
					// Result only nonzero while done is high
					if (!read_request) begin
						read_result <= '0;
						read_state <= register_map_pkg::READ_IDLE;
					end
				end
				default: begin
					read_result <= '0;
					read_state <= register_map_pkg::READ_IDLE;
				end
			endcase
		end
	end

	assign done_read_byte = (read_state == register_map_pkg::READ_DONE);

endmodule

/* source/register_map.sv */
// ========================================================================
// Register map top level, decoder, sequencers, settings and status
// ========================================================================
`timescale 1ns/1ps

module register_map (
	input logic system_clock,
	input logic reset,
	input logic t_pulse,
	input logic [register_map_pkg::STATUS_WIDTH-1:0] status_word,
	input logic write_byte,
	input logic [register_map_pkg::BYTE_WIDTH-1:0] byte_to_write,
	input logic [register_map_pkg::ADDRESS_WIDTH-1:0] address,	// Shared by reads and writes
	input logic read_byte,
	output logic done_write_byte,
	output logic done_read_byte,
	output logic [register_map_pkg::BYTE_WIDTH-1:0] read_result,
	output logic enable_aclk,
	output logic enable_auto,
	output logic enable_saving,
	output logic [register_map_pkg::BYTE_WIDTH-1:0] seq_limit,
	output logic [register_map_pkg::CRITERIA_WIDTH-1:0] a_criteria,
	output logic [register_map_pkg::CRITERIA_WIDTH-1:0] b_criteria,
	output logic update_a,
	output logic update_b
);

	logic [register_map_pkg::SETTING_BYTES-1:0] write_select;
	logic [register_map_pkg::BYTE_WIDTH-1:0] read_data;
	logic write_enable;
	logic [register_map_pkg::SETTING_BYTES*register_map_pkg::BYTE_WIDTH-1:0] setting_bytes;
	logic [register_map_pkg::SNAPSHOT_BYTES*register_map_pkg::BYTE_WIDTH-1:0] snapshot_bytes;
	logic a_updated;
	logic b_updated;

	assign a_updated = status_word[register_map_pkg::A_UPDATED_BIT];
	assign b_updated = status_word[register_map_pkg::B_UPDATED_BIT];

	address_decoder address_decoder (
		.system_clock(system_clock),
		.reset(reset),
		.address(address),
		.setting_bytes(setting_bytes),
		.snapshot_bytes(snapshot_bytes),
		.write_select(write_select),
		.read_data(read_data)
	);

	write_sequencer write_sequencer (
		.system_clock(system_clock),
		.reset(reset),
		.write_byte(write_byte),
		.write_enable(write_enable),
		.done_write_byte(done_write_byte)
	);

	read_sequencer read_sequencer (
		.system_clock(system_clock),
		.reset(reset),
		.read_byte(read_byte),
		.read_data(read_data),
		.read_result(read_result),
		.done_read_byte(done_read_byte)
	);

	settings_bank settings_bank (
		.system_clock(system_clock),
		.reset(reset),
		.write_enable(write_enable),
		.write_select(write_select),
		.byte_to_write(byte_to_write),
		.a_updated(a_updated),
		.b_updated(b_updated),
		.setting_bytes(setting_bytes),
		.enable_aclk(enable_aclk),
		.enable_auto(enable_auto),
		.enable_saving(enable_saving),
		.seq_limit(seq_limit),
		.a_criteria(a_criteria),
		.b_criteria(b_criteria),
		.update_a(update_a),
		.update_b(update_b)
	);

	status_capture status_capture (
		.system_clock(system_clock),
		.reset(reset),
		.t_pulse(t_pulse),
		.status_word(status_word),
		.snapshot_bytes(snapshot_bytes)
	);

endmodule

/* source/register_map_pkg.sv */
// ========================================================================
// Register map widths, bit positions, reset defaults and encodings
// ========================================================================
package register_map_pkg;

	localparam int BYTE_WIDTH = 8;		// One byte on the command bus
	localparam int ADDRESS_WIDTH = 4;
	localparam int SETTING_BYTES = 10;	// Writable bytes, also one-hot select width
	localparam int SNAPSHOT_BYTES = 5;	// Marker count plus four status bytes
	localparam int STATUS_WIDTH = 26;
	localparam int CRITERIA_WIDTH = 29;	// Coincidence bit above four fields
	localparam int DURATION_WIDTH = 6;
	localparam int MISC_WIDTH = 5;

	// Status word
	localparam int A_UPDATED_BIT = 17;	// Channel A took its new criteria
	localparam int B_UPDATED_BIT = 16;
	localparam int MARKER_BIT = 19;		// Least-significant-bits marker

	// Misc control byte
	localparam int ACLK_BIT = 4;		// ADC sample clock enable
	localparam int AUTO_BIT = 3;		// Automatic entry creation
	localparam int SAVING_BIT = 2;
	localparam int A_COINC_BIT = 1;		// A requires coincidence
	localparam int B_COINC_BIT = 0;

	// Write selects that raise each channel's update request
	localparam logic [SETTING_BYTES-1:0] A_UPDATE_MASK = 10'b01_1111_0000;
	localparam logic [SETTING_BYTES-1:0] B_UPDATE_MASK = 10'b01_0000_1111;

	localparam logic [BYTE_WIDTH-1:0] DEFAULT_MIN_DURATION = 8'd61;
	localparam logic [BYTE_WIDTH-1:0] DEFAULT_MAX_DURATION = 8'd62;
	localparam logic [BYTE_WIDTH-1:0] DEFAULT_MIN_AMPLITUDE = 8'd255;
	localparam logic [BYTE_WIDTH-1:0] DEFAULT_DOR_LIMIT = 8'd127;
	localparam logic [BYTE_WIDTH-1:0] DEFAULT_SEQ_LIMIT = 8'd64;
	localparam logic [BYTE_WIDTH-1:0] DEFAULT_MISC = 8'd0;	// All enables off

	// Byte addresses, channel B criteria first
	typedef enum logic [ADDRESS_WIDTH-1:0] {
		ADDR_B_DOR_LIMIT = 4'd0,
		ADDR_B_MIN_AMPLITUDE = 4'd1,
		ADDR_B_MAX_DURATION = 4'd2,
		ADDR_B_MIN_DURATION = 4'd3,
		ADDR_A_DOR_LIMIT = 4'd4,
		ADDR_A_MIN_AMPLITUDE = 4'd5,
		ADDR_A_MAX_DURATION = 4'd6,
		ADDR_A_MIN_DURATION = 4'd7,
		ADDR_MISC = 4'd8,
		ADDR_SEQ_LIMIT = 4'd9,
		ADDR_MARKER_COUNT = 4'd10,
		ADDR_STATUS_HIGH = 4'd11,	// Timepulse and status bits 25 to 24
		ADDR_STATUS_23_16 = 4'd12,
		ADDR_STATUS_15_8 = 4'd13,
		ADDR_STATUS_7_0 = 4'd14		// 15 is unassigned
	} reg_address_t;

	// Gray order, one bit changes per step
	typedef enum logic [1:0] {
		WRITE_IDLE = 2'b00,
		WRITE_START = 2'b01,
		WRITE_APPLY = 2'b11,
		WRITE_DONE = 2'b10
	} write_state_t;

	typedef enum logic [1:0] {
		READ_IDLE = 2'b00,
		READ_LOAD = 2'b01,
		READ_DONE = 2'b11
	} read_state_t;

endpackage

/* source/settings_bank.sv */
// ========================================================================
// Setting registers, registered output copies and update requests
// ========================================================================
`timescale 1ns/1ps

module settings_bank (
	input logic system_clock,
	input logic reset,
	input logic write_enable,
	input logic [register_map_pkg::SETTING_BYTES-1:0] write_select,	// One-hot
	input logic [register_map_pkg::BYTE_WIDTH-1:0] byte_to_write,
	input logic a_updated,		// Acknowledge from channel A monitor
	input logic b_updated,
	output logic [register_map_pkg::SETTING_BYTES*register_map_pkg::BYTE_WIDTH-1:0]
		setting_bytes,	// Raw bytes for readback
	output logic enable_aclk,
	output logic enable_auto,
	output logic enable_saving,
	output logic [register_map_pkg::BYTE_WIDTH-1:0] seq_limit,
	output logic [register_map_pkg::CRITERIA_WIDTH-1:0] a_criteria,
	output logic [register_map_pkg::CRITERIA_WIDTH-1:0] b_criteria,
	output logic update_a,
	output logic update_b
);

	logic [register_map_pkg::BYTE_WIDTH-1:0] setting_q [register_map_pkg::SETTING_BYTES];
	logic [register_map_pkg::BYTE_WIDTH-1:0] misc_byte;
	logic new_a;	// Write landed on A criteria or misc
	logic new_b;

	// Duration and misc bytes keep only their low bits
	function automatic logic [register_map_pkg::BYTE_WIDTH-1:0] field_mask(input int index);
		logic [register_map_pkg::BYTE_WIDTH-1:0] mask;
		case (register_map_pkg::reg_address_t'(index))
			register_map_pkg::ADDR_B_MAX_DURATION,
			register_map_pkg::ADDR_B_MIN_DURATION,
			register_map_pkg::ADDR_A_MAX_DURATION,
			register_map_pkg::ADDR_A_MIN_DURATION: begin
				mask = '0;
				mask[register_map_pkg::DURATION_WIDTH-1:0] = '1;
			end
			register_map_pkg::ADDR_MISC: begin
				mask = '0;
				mask[register_map_pkg::MISC_WIDTH-1:0] = '1;
			end
			default: mask = '1;
		endcase
		return mask;
	endfunction

	function automatic logic [register_map_pkg::BYTE_WIDTH-1:0] default_byte(input int index);
		case (register_map_pkg::reg_address_t'(index))
			register_map_pkg::ADDR_B_DOR_LIMIT,
			register_map_pkg::ADDR_A_DOR_LIMIT: return register_map_pkg::DEFAULT_DOR_LIMIT;
			register_map_pkg::ADDR_B_MIN_AMPLITUDE,
			register_map_pkg::ADDR_A_MIN_AMPLITUDE: return register_map_pkg::DEFAULT_MIN_AMPLITUDE;
			register_map_pkg::ADDR_B_MAX_DURATION,
			register_map_pkg::ADDR_A_MAX_DURATION: return register_map_pkg::DEFAULT_MAX_DURATION;
			register_map_pkg::ADDR_B_MIN_DURATION,
			register_map_pkg::ADDR_A_MIN_DURATION: return register_map_pkg::DEFAULT_MIN_DURATION;
			register_map_pkg::ADDR_MISC: return register_map_pkg::DEFAULT_MISC;
			default: return register_map_pkg::DEFAULT_SEQ_LIMIT;
		endcase
	endfunction

	// {coincidence, min_dur, max_dur, min_amp, DOR_limit}
	function automatic logic [register_map_pkg::CRITERIA_WIDTH-1:0] pack_criteria(
		input logic coincidence,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] dor_limit,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] min_amplitude,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] max_duration,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] min_duration
	);
		return {coincidence, min_duration[register_map_pkg::DURATION_WIDTH-1:0],
			max_duration[register_map_pkg::DURATION_WIDTH-1:0], min_amplitude, dor_limit};
	endfunction

	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < register_map_pkg::SETTING_BYTES; i++) begin
				setting_q[i] <= default_byte(i);
			end
		end else if (write_enable) begin
			for (int i = 0; i < register_map_pkg::SETTING_BYTES; i++) begin
				if (write_select[i]) setting_q[i] <= byte_to_write & field_mask(i);
			end
		end
	end

	for (genvar i = 0; i < register_map_pkg::SETTING_BYTES; i++) begin : g_readback
		assign setting_bytes[i*register_map_pkg::BYTE_WIDTH +: register_map_pkg::BYTE_WIDTH] =
			setting_q[i];
	end

	assign misc_byte = setting_q[register_map_pkg::ADDR_MISC];

	// Output copies trail the raw bytes by one cycle
	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			enable_aclk <= register_map_pkg::DEFAULT_MISC[register_map_pkg::ACLK_BIT];
			enable_auto <= register_map_pkg::DEFAULT_MISC[register_map_pkg::AUTO_BIT];
			enable_saving <= register_map_pkg::DEFAULT_MISC[register_map_pkg::SAVING_BIT];
			seq_limit <= register_map_pkg::DEFAULT_SEQ_LIMIT;
			a_criteria <= pack_criteria(register_map_pkg::DEFAULT_MISC[register_map_pkg::A_COINC_BIT],
				register_map_pkg::DEFAULT_DOR_LIMIT, register_map_pkg::DEFAULT_MIN_AMPLITUDE,
				register_map_pkg::DEFAULT_MAX_DURATION, register_map_pkg::DEFAULT_MIN_DURATION);
			b_criteria <= pack_criteria(register_map_pkg::DEFAULT_MISC[register_map_pkg::B_COINC_BIT],
				register_map_pkg::DEFAULT_DOR_LIMIT, register_map_pkg::DEFAULT_MIN_AMPLITUDE,
				register_map_pkg::DEFAULT_MAX_DURATION, register_map_pkg::DEFAULT_MIN_DURATION);
		end else begin
			enable_aclk <= misc_byte[register_map_pkg::ACLK_BIT];
			enable_auto <= misc_byte[register_map_pkg::AUTO_BIT];
			enable_saving <= misc_byte[register_map_pkg::SAVING_BIT];
			seq_limit <= setting_q[register_map_pkg::ADDR_SEQ_LIMIT];
			a_criteria <= pack_criteria(misc_byte[register_map_pkg::A_COINC_BIT],
				setting_q[register_map_pkg::ADDR_A_DOR_LIMIT],
				setting_q[register_map_pkg::ADDR_A_MIN_AMPLITUDE],
				setting_q[register_map_pkg::ADDR_A_MAX_DURATION],
				setting_q[register_map_pkg::ADDR_A_MIN_DURATION]);
			b_criteria <= pack_criteria(misc_byte[register_map_pkg::B_COINC_BIT],
				setting_q[register_map_pkg::ADDR_B_DOR_LIMIT],
				setting_q[register_map_pkg::ADDR_B_MIN_AMPLITUDE],
				setting_q[register_map_pkg::ADDR_B_MAX_DURATION],
				setting_q[register_map_pkg::ADDR_B_MIN_DURATION]);
		end
	end

	// Sticky requests, cleared by the channel's acknowledge
	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			new_a <= 1'b0;
			new_b <= 1'b0;
			update_a <= 1'b0;
			update_b <= 1'b0;
		end else begin
			new_a <= write_enable & |(write_select & register_map_pkg::A_UPDATE_MASK);
			new_b <= write_enable & |(write_select & register_map_pkg::B_UPDATE_MASK);
			update_a <= (new_a | update_a) & ~a_updated;	// Held until A acknowledges
			update_b <= (new_b | update_b) & ~b_updated;
		end
	end

endmodule

/* source/status_capture.sv */
// ========================================================================
// Marker edge counter and registered status snapshot
// ========================================================================
`timescale 1ns/1ps

module status_capture (
	input logic system_clock,
	input logic reset,
	input logic t_pulse,		// GNSS timepulse
	input logic [register_map_pkg::STATUS_WIDTH-1:0] status_word,
	output logic [register_map_pkg::SNAPSHOT_BYTES*register_map_pkg::BYTE_WIDTH-1:0]
		snapshot_bytes	// Count in the low byte
);

	logic marker_sample;
	logic marker_previous;
	logic [register_map_pkg::BYTE_WIDTH-1:0] marker_count;	// Wraps at 256
	logic [register_map_pkg::BYTE_WIDTH-1:0] status_high;

	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			marker_sample <= 1'b0;
			marker_previous <= 1'b0;
			marker_count <= '0;
		end else begin
			marker_sample <= status_word[register_map_pkg::MARKER_BIT];
			marker_previous <= marker_sample;
			if (marker_sample & ~marker_previous) begin	// Rising edge
				marker_count <= marker_count + 1'b1;
			end
		end
	end

	// Zeros, timepulse, then status bits 25 to 24
	assign status_high = {{(register_map_pkg::BYTE_WIDTH - 3){1'b0}}, t_pulse,
		status_word[register_map_pkg::STATUS_WIDTH-1 -: 2]};

	always_ff @(posedge system_clock) begin
		snapshot_bytes <= {status_word[7:0], status_word[15:8], status_word[23:16],
			status_high, marker_count};
	end

endmodule

/* source/write_sequencer.sv */
// ========================================================================
// Write command handshake FSM with a single write enable pulse
// ========================================================================
`timescale 1ns/1ps

module write_sequencer (
	input logic system_clock,
	input logic reset,
	input logic write_byte,			// Request from the command front end
	output logic write_enable,		// High for the APPLY cycle only
	output logic done_write_byte
);

	register_map_pkg::write_state_t write_state;
	logic write_request;	// Sampled request

	always_ff @(posedge system_clock or posedge reset) begin
		if (reset) begin
			write_request <= 1'b0;
			write_state <= register_map_pkg::WRITE_IDLE;
		end else begin
			write_request <= write_byte;
			case (write_state)
				register_map_pkg::WRITE_IDLE: begin
					if (write_request) begin
						write_state <= register_map_pkg::WRITE_START;
					end
				end
				// Select settles in START
				register_map_pkg::WRITE_START: write_state <= register_map_pkg::WRITE_APPLY;
				register_map_pkg::WRITE_APPLY: write_state <= register_map_pkg::WRITE_DONE;
				register_map_pkg::WRITE_DONE: begin
					if (!write_request) begin	// Master released the request
						write_state <= register_map_pkg::WRITE_IDLE;
					end
				end
				default: write_state <= register_map_pkg::WRITE_IDLE;
			endcase
		end
	end

	assign write_enable = (write_state == register_map_pkg::WRITE_APPLY);
	assign done_write_byte = (write_state == register_map_pkg::WRITE_DONE);	// Held while request stays high

endmodule

/* sources.f */
source/register_map_pkg.sv
source/address_decoder.sv
source/write_sequencer.sv
source/read_sequencer.sv
source/settings_bank.sv
source/status_capture.sv
source/register_map.sv
tests/register_map_tb.sv

/* tests/register_map_tb.sv */
// ========================================================================
// Register map testbench, reference model, compare tasks and watchdog
// ========================================================================
`timescale 1ns/1ps

module register_map_tb;

	localparam time CLOCK_PERIOD = 40;
	localparam int HANDSHAKE_LIMIT = 20;	// Cycles allowed for done to change
	localparam int COMMAND_COUNT = 480;		// Reads and writes over the whole run
	// 40 cycles per command plus room for the marker pulse train
	localparam time WATCHDOG_LIMIT = (COMMAND_COUNT * 40 + 3000) * CLOCK_PERIOD;

	logic system_clock = 1'b0;
	logic reset;
	logic t_pulse;
	logic [register_map_pkg::STATUS_WIDTH-1:0] status_word;
	logic write_byte;
	logic [register_map_pkg::BYTE_WIDTH-1:0] byte_to_write;
	logic [register_map_pkg::ADDRESS_WIDTH-1:0] address;
	logic read_byte;
	logic done_write_byte;
	logic done_read_byte;
	logic [register_map_pkg::BYTE_WIDTH-1:0] read_result;
	logic enable_aclk;
	logic enable_auto;
	logic enable_saving;
	logic [register_map_pkg::BYTE_WIDTH-1:0] seq_limit;
	logic [register_map_pkg::CRITERIA_WIDTH-1:0] a_criteria;
	logic [register_map_pkg::CRITERIA_WIDTH-1:0] b_criteria;
	logic update_a;
	logic update_b;

	logic [register_map_pkg::BYTE_WIDTH-1:0] model_bytes [register_map_pkg::SETTING_BYTES];
	logic [register_map_pkg::BYTE_WIDTH-1:0] expected_reads [$];	// Queued at each request
	int marker_edges = 0;	// Marker pulses driven so far
	logic read_done_previous = 1'b0;

	register_map uut (.*);

	always #(CLOCK_PERIOD / 2) system_clock = ~system_clock;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string what,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] expected,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0t: %s expected %02h got %02h",
				$time, what, expected, actual));
	endtask

	task automatic check_criteria(input string what,
		input logic [register_map_pkg::CRITERIA_WIDTH-1:0] expected,
		input logic [register_map_pkg::CRITERIA_WIDTH-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0t: %s expected %08h got %08h",
				$time, what, expected, actual));
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0t: %s expected %b got %b",
				$time, what, expected, actual));
	endtask

	// Durations (2, 3, 6, 7) and misc (8) keep only their low bits
	function automatic logic [register_map_pkg::BYTE_WIDTH-1:0] width_mask(input int index);
		case (index)
			2, 3, 6, 7: return 8'((1 << register_map_pkg::DURATION_WIDTH) - 1);
			8: return 8'((1 << register_map_pkg::MISC_WIDTH) - 1);
			default: return 8'hff;
		endcase
	endfunction

	function automatic logic [register_map_pkg::BYTE_WIDTH-1:0] expected_read(input int addr);
		case (addr)
			10: return 8'(marker_edges % 256);	// Count wraps
			11: return {5'b0, t_pulse, status_word[25:24]};
			12: return status_word[23:16];
			13: return status_word[15:8];
			14: return status_word[7:0];
			15: return '0;	// Unassigned
			default: return model_bytes[addr];
		endcase
	endfunction

	// Coincidence bit above min duration, max duration, min amplitude, DOR limit
	function automatic logic [register_map_pkg::CRITERIA_WIDTH-1:0] expected_criteria(
		input int base, input logic coincidence);
		return {coincidence, model_bytes[base+3][5:0], model_bytes[base+2][5:0],
			model_bytes[base+1], model_bytes[base]};
	endfunction

	task automatic check_outputs();
		logic [register_map_pkg::BYTE_WIDTH-1:0] misc;
		misc = model_bytes[8];
		check_criteria("a_criteria", expected_criteria(4, misc[1]), a_criteria);
		check_criteria("b_criteria", expected_criteria(0, misc[0]), b_criteria);
		check_flag("enable_aclk", misc[4], enable_aclk);
		check_flag("enable_auto", misc[3], enable_auto);
		check_flag("enable_saving", misc[2], enable_saving);
		check_byte("seq_limit", model_bytes[9], seq_limit);
	endtask

	// Polls done on falling edges until it reaches the wanted level
	task automatic wait_for_done(input logic write_side, input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge system_clock);
			cycles++;
			if (cycles > HANDSHAKE_LIMIT)
				fail_run($sformatf("Handshake timeout: %s done did not go to %b within %0d cycles",
					write_side ? "write" : "read", level, HANDSHAKE_LIMIT));
		end while ((write_side ? done_write_byte : done_read_byte) !== level);
	endtask

	task automatic write_register(input int addr,
		input logic [register_map_pkg::BYTE_WIDTH-1:0] data);
		@(posedge system_clock);
		address <= 4'(addr);
		byte_to_write <= data;
		write_byte <= 1'b1;
		wait_for_done(1'b1, 1'b1);
		@(posedge system_clock);
		write_byte <= 1'b0;	// Release the request so done falls
		wait_for_done(1'b1, 1'b0);
		if (addr < register_map_pkg::SETTING_BYTES) model_bytes[addr] = data & width_mask(addr);
	endtask

	task automatic read_register(input int addr);
		@(posedge system_clock);
		address <= 4'(addr);
		read_byte <= 1'b1;
		expected_reads.push_back(expected_read(addr));
		wait_for_done(1'b0, 1'b1);
		@(posedge system_clock);
		read_byte <= 1'b0;
		wait_for_done(1'b0, 1'b0);
	endtask

	task automatic pulse_status_bit(input int index, input int high_cycles, input int low_cycles);
		@(posedge system_clock);
		status_word[index] <= 1'b1;
		repeat (high_cycles) @(posedge system_clock);
		status_word[index] <= 1'b0;
		repeat (low_cycles) @(negedge system_clock);	// Ends on a stable sample point
	endtask

	// Read result compare on the rising edge of done
	always @(negedge system_clock) begin
		if (done_read_byte === 1'b1 && read_done_previous === 1'b0) begin
			if (expected_reads.size() == 0) fail_run("A read completed with no read outstanding");
			else check_byte("read_result", expected_reads.pop_front(), read_result);
		end
		read_done_previous = done_read_byte;
	end

	initial begin
		#(WATCHDOG_LIMIT);
		fail_run("Watchdog expired before the test sequence finished");
	end

	initial begin
		logic [register_map_pkg::STATUS_WIDTH-1:0] random_status;
		int pulses;
		void'($urandom(32'h14ea));
		reset = 1'b1;
		t_pulse = 1'b0;
		status_word = '0;
		write_byte = 1'b0;
		byte_to_write = '0;
		address = '0;
		read_byte = 1'b0;
		model_bytes[0] = register_map_pkg::DEFAULT_DOR_LIMIT;	// B bytes first
		model_bytes[1] = register_map_pkg::DEFAULT_MIN_AMPLITUDE;
		model_bytes[2] = register_map_pkg::DEFAULT_MAX_DURATION;
		model_bytes[3] = register_map_pkg::DEFAULT_MIN_DURATION;
		for (int i = 4; i < 8; i++) model_bytes[i] = model_bytes[i-4];
		model_bytes[8] = register_map_pkg::DEFAULT_MISC;
		model_bytes[9] = register_map_pkg::DEFAULT_SEQ_LIMIT;
		repeat (3) @(posedge system_clock);
		reset <= 1'b0;
		for (int addr = 0; addr <= 10; addr++) read_register(addr);	// Defaults and zero count
		check_outputs();
		for (int n = 0; n < 200; n++) begin
			int addr;
			addr = $urandom_range(0, 9);
			write_register(addr, 8'($urandom));
			check_outputs();
			read_register(addr);
		end
		for (int addr = 10; addr < 16; addr++) write_register(addr, 8'($urandom));	// Ignored
		for (int addr = 0; addr < 10; addr++) read_register(addr);
		check_outputs();
		pulse_status_bit(register_map_pkg::A_UPDATED_BIT, 2, 2);	// Clear leftover requests
		pulse_status_bit(register_map_pkg::B_UPDATED_BIT, 2, 2);
		check_flag("update_a", 1'b0, update_a);
		check_flag("update_b", 1'b0, update_b);
		write_register(register_map_pkg::ADDR_B_MIN_AMPLITUDE, 8'($urandom));
		repeat (5) @(negedge system_clock);	// Held with no acknowledge
		check_flag("update_b", 1'b1, update_b);
		check_flag("update_a", 1'b0, update_a);
		pulse_status_bit(register_map_pkg::B_UPDATED_BIT, 2, 2);
		check_flag("update_b", 1'b0, update_b);
		write_register(register_map_pkg::ADDR_MISC, 8'($urandom));	// Misc requests both
		check_outputs();
		check_flag("update_a", 1'b1, update_a);
		check_flag("update_b", 1'b1, update_b);
		pulse_status_bit(register_map_pkg::A_UPDATED_BIT, 2, 2);
		check_flag("update_a", 1'b0, update_a);
		check_flag("update_b", 1'b1, update_b);
		pulse_status_bit(register_map_pkg::B_UPDATED_BIT, 2, 2);
		check_flag("update_b", 1'b0, update_b);
		repeat (3) begin
			random_status = 26'($urandom);
			random_status[register_map_pkg::MARKER_BIT] = 1'b0;	// Count stays put
			@(posedge system_clock);
			status_word <= random_status;
			t_pulse <= 1'($urandom);
			for (int addr = 11; addr < 16; addr++) read_register(addr);
		end
		pulses = $urandom_range(1, 300);
		for (int p = 0; p < pulses; p++)
			pulse_status_bit(register_map_pkg::MARKER_BIT,
				$urandom_range(2, 3), $urandom_range(2, 3));
		marker_edges += pulses;
		read_register(10);
		$display("Simulation PASSED");
		$finish;
	end

endmodule
